// File: hw/dem_pkg.sv
package dem_pkg;

  // thermometer code from the modulator
  // legal range 0..16, so one bit more than log2 of the element count
  // codes 17..31 are illegal and get flagged by the sum check
  localparam int CODE_W = 5;

  // unit elements in the DAC array
  // also the width of the element select vector
  localparam int NUM_ELEMENTS = 16;

  // binary split levels between the root and the elements
  // root splits 5 bits, leaves split 2 bits into two single selects
  // level l holds 2**l cells of input width CODE_W - l
  localparam int TREE_LEVELS = 4;

  // two's complement width of each shaping integrator
  // first integrator stays within -1..+1 in steady use
  // second integrator saturates at -1 and +1
  localparam int SHAPE_W = 2;

  // selects right after reset
  // upper eight elements on, lower eight off
  // gives a mid-scale analog output before the first sample
  localparam logic [NUM_ELEMENTS-1:0] OUT_RESET_PATTERN = 16'hFF00;

  // element order in the select vector
  // bit 0 is the low half of leaf 0, bit 15 the high half of leaf 7
  // root high half ends up in bits 8..15

  // usage
  // tree: CODE_W, NUM_ELEMENTS, TREE_LEVELS
  // cell: SHAPE_W
  // output stage: CODE_W, NUM_ELEMENTS, OUT_RESET_PATTERN
  // top: CODE_W, NUM_ELEMENTS

  // the widths tie together
  // NUM_ELEMENTS equals 2**TREE_LEVELS
  // CODE_W equals TREE_LEVELS + 1
  // a leaf input of 2 bits covers the counts 0..2

endpackage

// File: hw/dem_split_cell.sv
// one node of the DEM tree
// splits an input count into two halves whose sum is the count
// an odd count leaves one unit over, and second-order shaping picks
// which half gets it so the mismatch error is pushed to high frequency
module dem_split_cell #(
  parameter int IN_W = 5
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            s3,
  input  logic [IN_W-1:0] code_in,
  output logic [IN_W-2:0] half_lo,
  output logic [IN_W-2:0] half_hi
);

  // one half of the input range
  typedef logic [IN_W-2:0] half_t;

  // signed integrator word
  typedef logic signed [dem_pkg::SHAPE_W-1:0] shape_t;

  // shaping state
  shape_t integ1;
  shape_t integ2;

  // steering bit, 1 sends the odd unit to the low half
  logic   steer;

  // count has a unit left over after halving
  logic   odd;

  // halving datapath
  half_t  low_part;
  half_t  floor_half;
  half_t  ceil_half;
  half_t  full_half;
  half_t  base_lo;
  half_t  base_hi;

  // lsb decides odd, also for the full-scale case
  assign odd = code_in[0];

  // steering from the integrators
  // first integrator wins when it is odd
  // otherwise the second one, otherwise no steering
  always_comb begin
    if (integ1[0]) begin
      steer = ~integ1[dem_pkg::SHAPE_W-1];
    end else if (integ2[0]) begin
      steer = ~integ2[dem_pkg::SHAPE_W-1];
    end else begin
      steer = 1'b0;
    end
  end

  // count below full scale without the top bit
  assign low_part = code_in[IN_W-2:0];

  // floor and ceiling of half the count
  assign floor_half = low_part >> 1;
  assign ceil_half  = floor_half + half_t'(low_part[0]);

  // half of full scale, only the top bit of a half set
  always_comb begin
    full_half = '0;
    full_half[IN_W-2] = 1'b1;
  end

  // top bit set means full scale
  // anything else in the lower bits is ignored here
  always_comb begin
    if (code_in[IN_W-1]) begin
      base_lo = full_half;
      base_hi = full_half;
    end else begin
      base_lo = floor_half;
      base_hi = ceil_half;
    end
  end

  // by default the high half carries the extra unit
  // swap when the count is odd and steering asks for it
  always_comb begin
    if (odd && steer) begin
      half_lo = base_hi;
      half_hi = base_lo;
    end else begin
      half_lo = base_lo;
      half_hi = base_hi;
    end
  end

  // first integrator
  // counts against the direction the odd unit went
  // even counts and idle cycles leave it alone
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      integ1 <= '0;
    end else if (s3 && odd) begin
      if (steer) begin
        integ1 <= integ1 - shape_t'(1);
      end else begin
        integ1 <= integ1 + shape_t'(1);
      end
    end
  end

  // second integrator
  // steps toward the old sign of the first one, every sample
  // saturates at -1 and +1
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      integ2 <= '0;
    end else if (s3) begin
      if (integ1 == shape_t'(1)) begin
        if (integ2 != shape_t'(1)) begin
          integ2 <= integ2 + shape_t'(1);
        end
      end else if (integ1 == shape_t'(-1)) begin
        if (integ2 != shape_t'(-1)) begin
          integ2 <= integ2 - shape_t'(1);
        end
      end
    end
  end

endmodule

// File: hw/dem_split_tree.sv
// binary tree of split cells
// root takes the full code, each level halves the counts again,
// leaves end up with single element selects
// purely combinational from data_in to tree_sel, state moves on s3
module dem_split_tree (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              s3,
  input  logic [dem_pkg::CODE_W-1:0]        data_in,
  output logic [dem_pkg::NUM_ELEMENTS-1:0]  tree_sel
);

  // every node carried at full code width, upper bits zero
  typedef logic [dem_pkg::CODE_W-1:0] node_t;

  // heap-ordered node array
  // node 1 is the root input
  // node n feeds its cell, which drives nodes 2n (low) and 2n+1 (high)
  // level l owns nodes 2**l .. 2**(l+1)-1
  // last level nodes are the element selects
  node_t node [1:2*dem_pkg::NUM_ELEMENTS-1];

  // root takes the code straight from the port
  assign node[1] = data_in;

  // one generate block per level
  for (genvar l = 0; l < dem_pkg::TREE_LEVELS; l++) begin : g_level

    // cell input width shrinks by one bit per level
    localparam int CELL_W = dem_pkg::CODE_W - l;

    // cells on this level, also the first node index
    localparam int CELLS = 1 << l;

    for (genvar j = 0; j < CELLS; j++) begin : g_cell

      // halves at this level's output width
      logic [CELL_W-2:0] half_lo;
      logic [CELL_W-2:0] half_hi;

      // cell j reads its node, narrowed to the level width
      dem_split_cell #(
        .IN_W    (CELL_W)
      ) u_cell (
        .clk     (clk),
        .rst     (rst),
        .s3      (s3),
        .code_in (node[CELLS+j][CELL_W-1:0]),
        .half_lo (half_lo),
        .half_hi (half_hi)
      );

      // low half to cell 2j of the next level, high half to 2j+1
      assign node[2*(CELLS+j)]   = node_t'(half_lo);
      assign node[2*(CELLS+j)+1] = node_t'(half_hi);

    end
  end

  // leaf outputs
  // nodes NUM_ELEMENTS .. 2*NUM_ELEMENTS-1 hold one bit each
  // leaf j gives element 2j from its low half, 2j+1 from its high half
  for (genvar e = 0; e < dem_pkg::NUM_ELEMENTS; e++) begin : g_leaf
    assign tree_sel[e] = node[dem_pkg::NUM_ELEMENTS+e][0];
  end

  // upper node bits only exist to keep one array type
  // node_t cast zero fills them

endmodule

// File: hw/dem_output_stage.sv
// element select register and sum check
// selects are captured on sample edges and held in between
// the check counts the selected elements and compares with the code
module dem_output_stage (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              s3,
  input  logic                              error_clear,
  input  logic [dem_pkg::CODE_W-1:0]        data_in,
  input  logic [dem_pkg::NUM_ELEMENTS-1:0]  tree_sel,
  output logic [dem_pkg::NUM_ELEMENTS-1:0]  dem_out,
  output logic                              error
);

  // element count fits the code width, 0..16
  typedef logic [dem_pkg::CODE_W-1:0] count_t;

  // adder tree shape
  // four elements per group, then pairs of groups
  localparam int QUADS = dem_pkg::NUM_ELEMENTS / 4;
  localparam int PAIRS = QUADS / 2;

  // partial sums
  count_t quad_sum [QUADS];
  count_t pair_sum [PAIRS];
  count_t ones_count;

  // code and select count disagree
  logic   sum_mismatch;

  // first level, ones in each group of four
  always_comb begin
    for (int q = 0; q < QUADS; q++) begin
      quad_sum[q] = count_t'(tree_sel[4*q])
                  + count_t'(tree_sel[4*q+1])
                  + count_t'(tree_sel[4*q+2])
                  + count_t'(tree_sel[4*q+3]);
    end
  end

  // second level, neighbouring groups
  always_comb begin
    for (int p = 0; p < PAIRS; p++) begin
      pair_sum[p] = quad_sum[2*p] + quad_sum[2*p+1];
    end
  end

  // last level, all pairs
  always_comb begin
    ones_count = '0;
    for (int p = 0; p < PAIRS; p++) begin
      ones_count = ones_count + pair_sum[p];
    end
  end

  // only illegal codes can miss here
  // the tree caps at full scale, so 17..31 give 16 ones
  assign sum_mismatch = (ones_count != data_in);

  // select register
  // reset to mid scale, load on sample, hold otherwise
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dem_out <= dem_pkg::OUT_RESET_PATTERN;
    end else if (s3) begin
      dem_out <= tree_sel;
    end
  end

  // sticky error flag
  // clear wins over a new mismatch on the same edge
  // clear works with or without a sample
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      error <= 1'b0;
    end else if (error_clear) begin
      error <= 1'b0;
    end else if (s3 && sum_mismatch) begin
      error <= 1'b1;
    end
  end

endmodule

// File: hw/dem_top.sv
// DEM encoder for a 16 element unit DAC
// code goes through the split tree into the output register,
// the sum check sits next to the register
// one sample per clk edge with s3 high
// dem_out follows data_in by one edge
module dem_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              s3,
  input  logic [dem_pkg::CODE_W-1:0]        data_in,
  input  logic                              error_clear,
  output logic [dem_pkg::NUM_ELEMENTS-1:0]  dem_out,
  output logic                              error
);

  // unregistered selects from the tree leaves
  logic [dem_pkg::NUM_ELEMENTS-1:0] tree_sel;

  // split tree
  // fed straight from the port, no input register
  // shaping state advances on the same edge that loads dem_out
  dem_split_tree u_tree (
    .clk      (clk),
    .rst      (rst),
    .s3       (s3),
    .data_in  (data_in),
    .tree_sel (tree_sel)
  );

  // output register and sum check
  // sees the same data_in as the tree for the count compare
  dem_output_stage u_out (
    .clk         (clk),
    .rst         (rst),
    .s3          (s3),
    .error_clear (error_clear),
    .data_in     (data_in),
    .tree_sel    (tree_sel),
    .dem_out     (dem_out),
    .error       (error)
  );

  // no back-pressure
  // every strobed sample is taken, s3 low freezes everything

endmodule

// File: sim/tb_dem_top.sv
// testbench for the DEM encoder top level
// stimulus runs through the phases, concurrent assertions do the checks
// expected values come from the count, hold, extreme and shaping rules
module tb_dem_top;
  timeunit 1ns;
  timeprecision 100ps;

  // clock and run length
  localparam int CLK_PERIOD      = 100;
  localparam int SEED            = 22;
  localparam int RESET_CYCLES    = 5;
  localparam int PATTERN_SAMPLES = 16;
  localparam int RANDOM_SAMPLES  = 200;
  localparam int TAIL_CYCLES     = 48;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + PATTERN_SAMPLES + RANDOM_SAMPLES
                                 + TAIL_CYCLES;
  localparam int WATCHDOG_MARGIN = 2;

  // code and select constants
  localparam int NE = dem_pkg::NUM_ELEMENTS;
  localparam logic [dem_pkg::CODE_W-1:0] FULL_CODE = dem_pkg::CODE_W'(NE);
  localparam logic [NE-1:0] ALL_ON      = {NE{1'b1}};
  localparam logic [NE-1:0] UPPER_EIGHT = {{(NE/2){1'b1}}, {(NE/2){1'b0}}};

  // DUT ports
  logic                        clk = 1'b0;
  logic                        rst;
  logic                        s3;
  logic [dem_pkg::CODE_W-1:0]  data_in;
  logic                        error_clear;
  logic [NE-1:0]               dem_out;
  logic                        error;

  // shaping phase markers, driven along with the code
  logic pat_on;
  int   pat_idx;

  // what the previous edge did, captured on that edge
  logic                        rst_seen    = 1'b0;
  logic                        sampled_yet = 1'b0;
  logic                        prev_sample = 1'b0;
  logic                        prev_idle   = 1'b0;
  logic                        prev_pat    = 1'b0;
  int                          prev_pat_idx = 0;
  logic [dem_pkg::CODE_W-1:0]  prev_code   = '0;
  logic [NE-1:0]               prev_out    = '0;

  // reference sticky flag
  logic exp_error = 1'b0;

  // derived views of the outputs
  int            out_ones;
  logic [NE-1:0] exp_region;

  dem_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .s3          (s3),
    .data_in     (data_in),
    .error_clear (error_clear),
    .dem_out     (dem_out),
    .error       (error)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign out_ones = $countones(dem_out);

  // root shaping from reset with code 1
  // upper, lower, lower, upper, then again
  assign exp_region = (prev_pat_idx % 4 == 0 || prev_pat_idx % 4 == 3) ?
                      UPPER_EIGHT : ~UPPER_EIGHT;

  // capture each edge's inputs for the checks one edge later
  always @(posedge clk) begin
    rst_seen     <= rst_seen | rst;
    sampled_yet  <= sampled_yet | (!rst && s3);
    prev_sample  <= !rst && s3;
    prev_idle    <= !rst && !s3;
    prev_pat     <= !rst && s3 && pat_on;
    prev_pat_idx <= pat_idx;
    prev_code    <= data_in;
    prev_out     <= dem_out;
    // illegal codes always miss the count, legal ones never
    if (rst) begin
      exp_error <= 1'b0;
    end else if (error_clear) begin
      exp_error <= 1'b0;
    end else if (s3 && data_in > FULL_CODE) begin
      exp_error <= 1'b1;
    end
  end

  task automatic report_value_error(input string name, input logic [31:0] got,
                                    input logic [31:0] expected);
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
    $display("TESTS FAILED");
    $fatal(1, "check on %s failed", name);
  endtask

  // one sample or idle cycle, driven on the rising edge
  task automatic apply_input(input logic [dem_pkg::CODE_W-1:0] code, input logic strobe,
                             input logic clear);
    @(posedge clk);
    data_in     <= code;
    s3          <= strobe;
    error_clear <= clear;
    pat_on      <= 1'b0;
  endtask

  // code 1 sample tagged with its place in the run
  task automatic apply_pattern_sample(input int idx);
    @(posedge clk);
    data_in     <= dem_pkg::CODE_W'(1);
    s3          <= 1'b1;
    error_clear <= 1'b0;
    pat_on      <= 1'b1;
    pat_idx     <= idx;
  endtask

  // reset value until the first sample lands
  reset_out_check: assert property (@(posedge clk)
      rst_seen && !sampled_yet |-> dem_out == dem_pkg::OUT_RESET_PATTERN)
    else report_value_error("dem_out", 32'($sampled(dem_out)),
                            32'(dem_pkg::OUT_RESET_PATTERN));

  reset_err_check: assert property (@(posedge clk)
      rst_seen && !sampled_yet |-> !error)
    else report_value_error("error", 32'($sampled(error)), 32'(0));

  // number of selected elements equals a legal code
  count_check: assert property (@(posedge clk)
      prev_sample && (prev_code <= FULL_CODE) |-> out_ones == int'(prev_code))
    else report_value_error("ones in dem_out", 32'($sampled(out_ones)),
                            32'($sampled(prev_code)));

  // no strobe, no change
  hold_check: assert property (@(posedge clk)
      prev_idle |-> dem_out == prev_out)
    else report_value_error("dem_out", 32'($sampled(dem_out)), 32'($sampled(prev_out)));

  zero_check: assert property (@(posedge clk)
      prev_sample && prev_code == '0 |-> dem_out == '0)
    else report_value_error("dem_out", 32'($sampled(dem_out)), 32'(0));

  // 16 and all illegal codes turn every element on
  full_check: assert property (@(posedge clk)
      prev_sample && prev_code >= FULL_CODE |-> dem_out == ALL_ON)
    else report_value_error("dem_out", 32'($sampled(dem_out)), 32'(ALL_ON));

  // sticky flag against the reference
  error_check: assert property (@(posedge clk)
      rst_seen |-> error == exp_error)
    else report_value_error("error", 32'($sampled(error)), 32'($sampled(exp_error)));

  // single element must sit in the expected half
  pattern_check: assert property (@(posedge clk)
      prev_pat |-> (dem_out & ~exp_region) == '0)
    else report_value_error("dem_out outside half", 32'($sampled(dem_out)),
                            32'($sampled(exp_region)));

  initial begin
    void'($urandom(SEED));
    rst         = 1'b1;
    s3          = 1'b0;
    data_in     = '0;
    error_clear = 1'b0;
    pat_on      = 1'b0;
    pat_idx     = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // code 1 on every cycle straight out of reset
    for (int i = 0; i < PATTERN_SAMPLES; i++) begin
      apply_pattern_sample(i);
    end

    // random legal codes, strobe high three times in four
    for (int i = 0; i < RANDOM_SAMPLES; i++) begin
      apply_input(dem_pkg::CODE_W'($urandom_range(16, 0)), ($urandom_range(3, 0) != 0),
                  1'b0);
    end

    // extremes, with holds in between
    apply_input(5'd0, 1'b1, 1'b0);
    apply_input(5'd0, 1'b1, 1'b0);
    apply_input(5'd16, 1'b1, 1'b0);
    apply_input(5'd16, 1'b1, 1'b0);
    apply_input(5'd0, 1'b0, 1'b0);
    apply_input(5'd16, 1'b0, 1'b0);
    apply_input(5'd0, 1'b1, 1'b0);
    apply_input(5'd16, 1'b1, 1'b0);

    // illegal codes set the flag
    apply_input(5'd17, 1'b1, 1'b0);
    apply_input(dem_pkg::CODE_W'($urandom_range(31, 17)), 1'b1, 1'b0);
    // flag stays up through legal samples
    for (int i = 0; i < 6; i++) begin
      apply_input(dem_pkg::CODE_W'($urandom_range(16, 0)), 1'b1, 1'b0);
    end
    // unstrobed illegal code is ignored
    apply_input(5'd31, 1'b0, 1'b0);

    // clear beats an illegal sample on the same edge
    apply_input(5'd20, 1'b1, 1'b1);
    apply_input(5'd3, 1'b1, 1'b0);
    apply_input(5'd25, 1'b1, 1'b0);
    apply_input(5'd5, 1'b1, 1'b0);

    // clear with the strobe low
    apply_input(5'd9, 1'b0, 1'b1);
    for (int i = 0; i < 6; i++) begin
      apply_input(dem_pkg::CODE_W'($urandom_range(16, 0)), 1'b1, 1'b0);
    end
    apply_input(5'd0, 1'b0, 1'b0);

    // let the last sample get checked
    repeat (3) @(posedge clk);
    @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_MARGIN * TOTAL_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the stimulus finished");
    $display("TESTS FAILED");
    $fatal(1, "run timed out");
  end

endmodule

// File: dem_top.f
hw/dem_pkg.sv
hw/dem_split_cell.sv
hw/dem_split_tree.sv
hw/dem_output_stage.sv
hw/dem_top.sv
sim/tb_dem_top.sv

// File: run.sh
#!/bin/sh
# compile and run the DEM encoder testbench with Verilator
# the simulator exit status carries pass or fail
set -e

cd "$(dirname "$0")"

TOP=tb_dem_top
BUILD_DIR=obj_dir

# build the simulation binary from the file list
verilator --binary --timing --assert \
  -f dem_top.f \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -o "$TOP"

# run it, a failing check ends with a non-zero status
"./$BUILD_DIR/$TOP"

echo "simulation finished"
